// ==== rtl/dram_domain_pkg.sv ====
package dram_domain_pkg;

    // word layout: payload in 31..15, opcode in 14..0
    localparam int CMD_W     = 32;
    localparam int OPCODE_W  = 15;
    localparam int PAYLOAD_W = CMD_W - OPCODE_W;
    localparam int HALF_W    = 16;

    // dram application port
    localparam int DATA_W     = 256;
    localparam int APP_ADDR_W = 29;
    localparam int ADDR_W     = 32;

    // one 256-bit beat covers eight 32-bit address units
    localparam logic [ADDR_W-1:0] BEAT_STEP = 32'd8;

    // configuration stream
    localparam int CONFIG_WORDS = 40;
    localparam int CFG_CNT_W    = 6;

    typedef enum logic [OPCODE_W-1:0] {
        op_config     = 15'd1,
        op_asic_done  = 15'd2,
        op_dram_ready = 15'd3,
        op_window     = 15'd4,
        op_verify     = 15'd5,
        op_count      = 15'd6
    } opcode_e;

    typedef enum logic [2:0] {
        app_write = 3'd0,
        app_read  = 3'd1
    } app_cmd_e;

    typedef struct packed {
        logic [PAYLOAD_W-1:0] payload;
        logic [OPCODE_W-1:0]  opcode;
    } cmd_word_t;

endpackage

// ==== rtl/host_cmd_engine.sv ====
`timescale 1ns/1ns

module host_cmd_engine (
    input  logic                              ui_clk,
    input  logic                              rst,
    input  dram_domain_pkg::cmd_word_t        p2d_cmd_dout,
    input  logic                              p2d_cmd_empty,
    output logic                              p2d_cmd_rd_en,
    input  logic                              d2a_cmd_full,
    output logic                              d2a_cmd_wr_en,
    output dram_domain_pkg::cmd_word_t        d2a_cmd_din,
    output logic [dram_domain_pkg::ADDR_W-1:0] win_base,
    output logic [dram_domain_pkg::ADDR_W-1:0] win_last,
    output logic                              win_start,
    output logic                              win_ack_req,
    input  logic                              win_ack_grant,
    output logic                              count_req,
    input  logic                              count_grant,
    output logic                              cfg_done_level,
    input  logic                              cfg_clear
);
    import dram_domain_pkg::*;

    logic [CFG_CNT_W-1:0] cfg_cnt;
    logic [CFG_CNT_W-1:0] cnt_base;
    logic [1:0]           win_half;
    logic                 win_ack_pend;
    logic                 count_pend;
    logic                 cfg_pop;
    logic                 win_pop;
    logic                 count_pop;
    logic                 drop_pop;

    // pop decision on the head word
    always_comb begin
        cfg_pop   = 1'b0;
        win_pop   = 1'b0;
        count_pop = 1'b0;
        drop_pop  = 1'b0;
        if (!p2d_cmd_empty) begin
            case (p2d_cmd_dout.opcode)
                op_config: cfg_pop = !d2a_cmd_full;
                // last half needs a free ack slot
                op_window: win_pop = (win_half != 2'd3) || !win_ack_pend;
                op_count:  count_pop = !count_pend;
                default:   drop_pop = 1'b1;
            endcase
        end
    end

    assign p2d_cmd_rd_en = cfg_pop | win_pop | count_pop | drop_pop;

    // requests include the pop cycle so an idle mux answers at once
    assign win_ack_req = win_ack_pend | (win_pop && win_half == 2'd3);
    assign count_req   = count_pend | count_pop;

    assign cnt_base = cfg_clear ? '0 : cfg_cnt;

    always_ff @(posedge ui_clk) begin
        if (rst) begin
            cfg_cnt        <= '0;
            cfg_done_level <= 1'b0;
            d2a_cmd_wr_en  <= 1'b0;
            win_half       <= 2'd0;
            win_start      <= 1'b0;
            win_base       <= '0;
            win_last       <= '0;
            win_ack_pend   <= 1'b0;
            count_pend     <= 1'b0;
        end else begin
            d2a_cmd_wr_en <= cfg_pop;
            win_start     <= win_pop && win_half == 2'd0;
            win_ack_pend  <= win_ack_req && !win_ack_grant;
            count_pend    <= count_req && !count_grant;

            cfg_cnt <= cnt_base;
            if (cfg_clear) begin
                cfg_done_level <= 1'b0;
            end
            if (cfg_pop) begin
                // count holds at the final value, the word there completes the stream
                if (cnt_base == CONFIG_WORDS - 1) begin
                    cfg_done_level <= 1'b1;
                end else begin
                    cfg_cnt <= cnt_base + 1'b1;
                end
            end

            if (win_pop) begin
                win_half <= win_half + 2'd1;
                case (win_half)
                    2'd0: win_base[HALF_W-1:0] <= p2d_cmd_dout.payload[HALF_W-1:0];
                    2'd1: win_base[ADDR_W-1:HALF_W] <= p2d_cmd_dout.payload[HALF_W-1:0];
                    2'd2: win_last[HALF_W-1:0] <= p2d_cmd_dout.payload[HALF_W-1:0];
                    default: win_last[ADDR_W-1:HALF_W] <= p2d_cmd_dout.payload[HALF_W-1:0];
                endcase
            end
        end
    end

    // forwarded config word
    always_ff @(posedge ui_clk) begin
        if (cfg_pop) begin
            d2a_cmd_din <= p2d_cmd_dout;
        end
    end

endmodule

// ==== rtl/app_port_ctrl.sv ====
`timescale 1ns/1ns

module app_port_ctrl (
    input  logic                                 ui_clk,
    input  logic                                 rst,
    input  logic [dram_domain_pkg::DATA_W-1:0]    p2d_data_dout,
    input  logic                                 p2d_data_empty,
    output logic                                 p2d_data_rd_en,
    output logic                                 app_en,
    output dram_domain_pkg::app_cmd_e            app_cmd,
    output logic [dram_domain_pkg::APP_ADDR_W-1:0] app_addr,
    output logic                                 app_wdf_wren,
    output logic [dram_domain_pkg::DATA_W-1:0]    app_wdf_data,
    input  logic                                 app_rdy,
    input  logic                                 app_wdf_rdy,
    input  logic [dram_domain_pkg::DATA_W-1:0]    app_rd_data,
    input  logic                                 app_rd_data_valid,
    input  logic [dram_domain_pkg::ADDR_W-1:0]    win_base,
    input  logic [dram_domain_pkg::ADDR_W-1:0]    win_last,
    input  logic                                 win_start,
    output logic [dram_domain_pkg::ADDR_W-1:0]    write_count,
    output logic                                 verify_req,
    input  logic                                 verify_grant,
    output logic [dram_domain_pkg::PAYLOAD_W-1:0] verify_data
);
    import dram_domain_pkg::*;

    typedef enum logic [1:0] {
        st_idle,
        st_read_issue,
        st_read_wait,
        st_report
    } chk_state_e;

    chk_state_e        state;
    logic [ADDR_W-1:0] beat_addr;
    logic              read_go;

    assign beat_addr = win_base + write_count;

    // beats stall while a read-back check is in flight
    assign p2d_data_rd_en = !p2d_data_empty && app_rdy && app_wdf_rdy && (state == st_idle);
    assign read_go        = (state == st_read_issue) && app_rdy;
    assign verify_req     = (state == st_report);

    always_ff @(posedge ui_clk) begin
        if (rst) begin
            state        <= st_idle;
            write_count  <= '0;
            app_en       <= 1'b0;
            app_wdf_wren <= 1'b0;
        end else begin
            app_en       <= p2d_data_rd_en || read_go;
            app_wdf_wren <= p2d_data_rd_en;

            if (win_start) begin
                write_count <= '0;
            end else if (p2d_data_rd_en) begin
                write_count <= write_count + BEAT_STEP;
            end

            case (state)
                st_idle: begin
                    if (p2d_data_rd_en && beat_addr == win_last) begin
                        state <= st_read_issue;
                    end
                end
                st_read_issue: begin
                    if (app_rdy) begin
                        state <= st_read_wait;
                    end
                end
                st_read_wait: begin
                    if (app_rd_data_valid) begin
                        state <= st_report;
                    end
                end
                st_report: begin
                    if (verify_grant) begin
                        state <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    // command, address and data only matter while app_en or app_wdf_wren is high
    always_ff @(posedge ui_clk) begin
        if (p2d_data_rd_en) begin
            app_cmd      <= app_write;
            app_addr     <= beat_addr[APP_ADDR_W-1:0];
            app_wdf_data <= p2d_data_dout;
        end else if (read_go) begin
            app_cmd  <= app_read;
            app_addr <= win_last[APP_ADDR_W-1:0];
        end
        // first valid beat only
        if (state == st_read_wait && app_rd_data_valid) begin
            verify_data <= app_rd_data[PAYLOAD_W-1:0];
        end
    end

endmodule

// ==== rtl/status_mux.sv ====
`timescale 1ns/1ns

module status_mux (
    input  logic                                 ui_clk,
    input  logic                                 rst,
    input  logic                                 init_calib_complete,
    input  logic                                 d2p_cmd_full,
    output logic                                 d2p_cmd_wr_en,
    output dram_domain_pkg::cmd_word_t           d2p_cmd_din,
    input  dram_domain_pkg::cmd_word_t           a2d_cmd_dout,
    input  logic                                 a2d_cmd_empty,
    output logic                                 a2d_cmd_rd_en,
    input  logic                                 cfg_done_level,
    output logic                                 cfg_clear,
    input  logic                                 win_ack_req,
    output logic                                 win_ack_grant,
    input  logic                                 count_req,
    output logic                                 count_grant,
    input  logic [dram_domain_pkg::ADDR_W-1:0]    write_count,
    input  logic                                 verify_req,
    input  logic [dram_domain_pkg::PAYLOAD_W-1:0] verify_data,
    output logic                                 verify_grant
);
    import dram_domain_pkg::*;

    logic      ready_sent;
    logic      ready_grant;
    logic      done_req;
    logic      done_pop;
    logic      drop_pop;
    logic      any_grant;
    cmd_word_t next_word;

    // fixed priority: verify, window ack, count, asic done, dram ready
    always_comb begin
        verify_grant  = 1'b0;
        win_ack_grant = 1'b0;
        count_grant   = 1'b0;
        done_pop      = 1'b0;
        ready_grant   = 1'b0;
        next_word     = '0;
        done_req = !a2d_cmd_empty && a2d_cmd_dout.opcode == op_asic_done && cfg_done_level;
        // anything other than done has no use on the host side
        drop_pop = !a2d_cmd_empty && a2d_cmd_dout.opcode != op_asic_done;
        if (!d2p_cmd_full) begin
            if (verify_req) begin
                verify_grant      = 1'b1;
                next_word.payload = verify_data;
                next_word.opcode  = op_verify;
            end else if (win_ack_req) begin
                win_ack_grant    = 1'b1;
                next_word.opcode = op_window;
            end else if (count_req) begin
                count_grant       = 1'b1;
                next_word.payload = write_count[PAYLOAD_W-1:0];
                next_word.opcode  = op_count;
            end else if (done_req) begin
                done_pop  = 1'b1;
                next_word = a2d_cmd_dout;
            end else if (init_calib_complete && !ready_sent) begin
                ready_grant      = 1'b1;
                next_word.opcode = op_dram_ready;
            end
        end
        any_grant = verify_grant | win_ack_grant | count_grant | done_pop | ready_grant;
    end

    assign a2d_cmd_rd_en = done_pop | drop_pop;
    assign cfg_clear     = done_pop;

    always_ff @(posedge ui_clk) begin
        if (rst) begin
            d2p_cmd_wr_en <= 1'b0;
            ready_sent    <= 1'b0;
        end else begin
            d2p_cmd_wr_en <= any_grant;
            if (ready_grant) begin
                ready_sent <= 1'b1;
            end
        end
    end

    always_ff @(posedge ui_clk) begin
        if (any_grant) begin
            d2p_cmd_din <= next_word;
        end
    end

endmodule

// ==== rtl/dram_domain.sv ====
`timescale 1ns/1ns

module dram_domain (
    input  logic                                 ui_clk,
    input  logic                                 rst,
    input  logic                                 init_calib_complete,
    // host command fifo
    input  dram_domain_pkg::cmd_word_t           p2d_cmd_dout,
    input  logic                                 p2d_cmd_empty,
    output logic                                 p2d_cmd_rd_en,
    // host data fifo
    input  logic [dram_domain_pkg::DATA_W-1:0]    p2d_data_dout,
    input  logic                                 p2d_data_empty,
    output logic                                 p2d_data_rd_en,
    // host status fifo
    output dram_domain_pkg::cmd_word_t           d2p_cmd_din,
    output logic                                 d2p_cmd_wr_en,
    input  logic                                 d2p_cmd_full,
    // asic forward fifo
    output dram_domain_pkg::cmd_word_t           d2a_cmd_din,
    output logic                                 d2a_cmd_wr_en,
    input  logic                                 d2a_cmd_full,
    // asic command fifo
    input  dram_domain_pkg::cmd_word_t           a2d_cmd_dout,
    input  logic                                 a2d_cmd_empty,
    output logic                                 a2d_cmd_rd_en,
    // dram application port
    output logic                                 app_en,
    output dram_domain_pkg::app_cmd_e            app_cmd,
    output logic [dram_domain_pkg::APP_ADDR_W-1:0] app_addr,
    output logic                                 app_wdf_wren,
    output logic [dram_domain_pkg::DATA_W-1:0]    app_wdf_data,
    input  logic                                 app_rdy,
    input  logic                                 app_wdf_rdy,
    input  logic [dram_domain_pkg::DATA_W-1:0]    app_rd_data,
    input  logic                                 app_rd_data_valid
);
    import dram_domain_pkg::*;

    logic [ADDR_W-1:0]    win_base;
    logic [ADDR_W-1:0]    win_last;
    logic                 win_start;
    logic [ADDR_W-1:0]    write_count;
    logic                 cfg_done_level;
    logic                 cfg_clear;
    logic                 win_ack_req;
    logic                 win_ack_grant;
    logic                 count_req;
    logic                 count_grant;
    logic                 verify_req;
    logic                 verify_grant;
    logic [PAYLOAD_W-1:0] verify_data;

    host_cmd_engine host_cmd_engine_i (
        .ui_clk         (ui_clk),
        .rst            (rst),
        .p2d_cmd_dout   (p2d_cmd_dout),
        .p2d_cmd_empty  (p2d_cmd_empty),
        .p2d_cmd_rd_en  (p2d_cmd_rd_en),
        .d2a_cmd_full   (d2a_cmd_full),
        .d2a_cmd_wr_en  (d2a_cmd_wr_en),
        .d2a_cmd_din    (d2a_cmd_din),
        .win_base       (win_base),
        .win_last       (win_last),
        .win_start      (win_start),
        .win_ack_req    (win_ack_req),
        .win_ack_grant  (win_ack_grant),
        .count_req      (count_req),
        .count_grant    (count_grant),
        .cfg_done_level (cfg_done_level),
        .cfg_clear      (cfg_clear)
    );

    app_port_ctrl app_port_ctrl_i (
        .ui_clk            (ui_clk),
        .rst               (rst),
        .p2d_data_dout     (p2d_data_dout),
        .p2d_data_empty    (p2d_data_empty),
        .p2d_data_rd_en    (p2d_data_rd_en),
        .app_en            (app_en),
        .app_cmd           (app_cmd),
        .app_addr          (app_addr),
        .app_wdf_wren      (app_wdf_wren),
        .app_wdf_data      (app_wdf_data),
        .app_rdy           (app_rdy),
        .app_wdf_rdy       (app_wdf_rdy),
        .app_rd_data       (app_rd_data),
        .app_rd_data_valid (app_rd_data_valid),
        .win_base          (win_base),
        .win_last          (win_last),
        .win_start         (win_start),
        .write_count       (write_count),
        .verify_req        (verify_req),
        .verify_grant      (verify_grant),
        .verify_data       (verify_data)
    );

    status_mux status_mux_i (
        .ui_clk              (ui_clk),
        .rst                 (rst),
        .init_calib_complete (init_calib_complete),
        .d2p_cmd_full        (d2p_cmd_full),
        .d2p_cmd_wr_en       (d2p_cmd_wr_en),
        .d2p_cmd_din         (d2p_cmd_din),
        .a2d_cmd_dout        (a2d_cmd_dout),
        .a2d_cmd_empty       (a2d_cmd_empty),
        .a2d_cmd_rd_en       (a2d_cmd_rd_en),
        .cfg_done_level      (cfg_done_level),
        .cfg_clear           (cfg_clear),
        .win_ack_req         (win_ack_req),
        .win_ack_grant       (win_ack_grant),
        .count_req           (count_req),
        .count_grant         (count_grant),
        .write_count         (write_count),
        .verify_req          (verify_req),
        .verify_data         (verify_data),
        .verify_grant        (verify_grant)
    );

endmodule

// ==== dv/tb_clock.sv ====
`timescale 1ns/1ns

module tb_clock (
    output logic ui_clk
);
    // 10 ns period
    initial begin
        ui_clk = 1'b0;
        forever #5 ui_clk = ~ui_clk;
    end

endmodule

// ==== dv/dram_domain_asserts.sv ====
`timescale 1ns/1ns

module dram_domain_asserts (
    input logic ui_clk,
    input logic rst,
    input logic d2p_cmd_wr_en,
    input logic d2p_cmd_full,
    input logic d2a_cmd_wr_en,
    input logic d2a_cmd_full,
    input logic app_en,
    input logic app_rdy
);
    // a write is granted one cycle before its enable shows
    a_d2p_full: assert property (@(posedge ui_clk) disable iff (rst)
        d2p_cmd_wr_en |-> !$past(d2p_cmd_full))
        else $error("host status write while full");

    a_d2a_full: assert property (@(posedge ui_clk) disable iff (rst)
        d2a_cmd_wr_en |-> !$past(d2a_cmd_full))
        else $error("asic forward write while full");

    a_app_rdy: assert property (@(posedge ui_clk) disable iff (rst)
        app_en |-> $past(app_rdy))
        else $error("app_en raised without app_rdy");

endmodule

bind dram_domain dram_domain_asserts dram_domain_asserts_i (.*);

// ==== dv/dram_domain_checker.sv ====
`timescale 1ns/1ns

module dram_domain_checker (
    input  logic                                   ui_clk,
    input  logic                                   rst,
    input  logic                                   init_calib_complete,
    input  dram_domain_pkg::cmd_word_t             p2d_cmd_dout,
    input  logic                                   p2d_cmd_rd_en,
    input  logic [dram_domain_pkg::DATA_W-1:0]     p2d_data_dout,
    input  logic                                   p2d_data_rd_en,
    input  dram_domain_pkg::cmd_word_t             a2d_cmd_dout,
    input  logic                                   a2d_cmd_rd_en,
    input  dram_domain_pkg::cmd_word_t             d2p_cmd_din,
    input  logic                                   d2p_cmd_wr_en,
    input  dram_domain_pkg::cmd_word_t             d2a_cmd_din,
    input  logic                                   d2a_cmd_wr_en,
    input  logic                                   app_en,
    input  dram_domain_pkg::app_cmd_e              app_cmd,
    input  logic [dram_domain_pkg::APP_ADDR_W-1:0] app_addr,
    input  logic                                   app_wdf_wren,
    input  logic [dram_domain_pkg::DATA_W-1:0]     app_wdf_data,
    output int                                     error_count,
    output int                                     pending
);
    import dram_domain_pkg::*;

    cmd_word_t         exp_status[$];
    cmd_word_t         exp_fwd[$];
    logic [ADDR_W-1:0] exp_addr[$];
    logic [DATA_W-1:0] exp_data[$];
    logic [ADDR_W-1:0] base;
    logic [ADDR_W-1:0] last;
    logic [ADDR_W-1:0] addr;
    int                half = 0;
    int                beats = 0;
    int                cfg_pops = 0;
    int                errors = 0;
    int                pend = 0;
    bit                ready_seen = 0;

    assign error_count = errors;
    assign pending     = pend;

    // expected status word from opcode and its argument
    function automatic cmd_word_t ref_status(opcode_e op, logic [DATA_W-1:0] arg);
        cmd_word_t w;
        w.opcode = op;
        case (op)
            op_count:  w.payload = {arg[PAYLOAD_W-4:0], 3'b000};
            op_verify: w.payload = arg[PAYLOAD_W-1:0];
            default:   w.payload = '0;
        endcase
        return w;
    endfunction

    // status words may arrive in any order so match and remove
    task automatic take_status(cmd_word_t w);
        int idx;
        idx = -1;
        foreach (exp_status[i]) begin
            if (idx < 0 && exp_status[i] == w) idx = i;
        end
        if (idx < 0) begin
            errors++;
            $display("ERROR @%0t: unexpected status word %h", $time, w);
        end else begin
            exp_status.delete(idx);
        end
    endtask

    always @(negedge ui_clk) begin
        if (!rst) begin
            if (init_calib_complete && !ready_seen) begin
                ready_seen = 1;
                exp_status.push_back(ref_status(op_dram_ready, '0));
            end
            if (p2d_cmd_rd_en) begin
                case (p2d_cmd_dout.opcode)
                    op_config: begin
                        exp_fwd.push_back(p2d_cmd_dout);
                        cfg_pops++;
                    end
                    op_window: begin
                        case (half)
                            0: begin
                                base[15:0] = p2d_cmd_dout.payload[15:0];
                                beats = 0;
                            end
                            1: base[31:16] = p2d_cmd_dout.payload[15:0];
                            2: last[15:0] = p2d_cmd_dout.payload[15:0];
                            default: begin
                                last[31:16] = p2d_cmd_dout.payload[15:0];
                                exp_status.push_back(ref_status(op_window, '0));
                            end
                        endcase
                        half = (half + 1) % 4;
                    end
                    op_count: exp_status.push_back(ref_status(op_count, DATA_W'(beats)));
                    default: ;
                endcase
            end
            if (a2d_cmd_rd_en && a2d_cmd_dout.opcode == op_asic_done) begin
                if (cfg_pops != CONFIG_WORDS) begin
                    errors++;
                    $display("ERROR @%0t: done word released after %0d config words",
                             $time, cfg_pops);
                end
                cfg_pops = 0;
                exp_status.push_back(a2d_cmd_dout);
            end
            if (p2d_data_rd_en) begin
                addr = base + ADDR_W'(beats * 8);
                exp_addr.push_back(addr);
                exp_data.push_back(p2d_data_dout);
                if (addr == last) exp_status.push_back(ref_status(op_verify, p2d_data_dout));
                beats++;
            end
            if (app_en && app_wdf_wren && app_cmd == app_write) begin
                if (exp_addr.size() == 0) begin
                    errors++;
                    $display("ERROR @%0t: unexpected dram write at %h", $time, app_addr);
                end else begin
                    if (app_addr != exp_addr[0][APP_ADDR_W-1:0] ||
                        app_wdf_data != exp_data[0]) begin
                        errors++;
                        $display("ERROR @%0t: dram write at %h, expected %h", $time,
                                 app_addr, exp_addr[0][APP_ADDR_W-1:0]);
                    end
                    void'(exp_addr.pop_front());
                    void'(exp_data.pop_front());
                end
            end
            // read-back only ever targets the window's last address
            if (app_en && app_cmd == app_read && app_addr != last[APP_ADDR_W-1:0]) begin
                errors++;
                $display("ERROR @%0t: dram read at %h, expected %h", $time,
                         app_addr, last[APP_ADDR_W-1:0]);
            end
            if (d2a_cmd_wr_en) begin
                if (exp_fwd.size() == 0 || exp_fwd[0] != d2a_cmd_din) begin
                    errors++;
                    $display("ERROR @%0t: forward word %h out of order", $time, d2a_cmd_din);
                end
                if (exp_fwd.size() != 0) void'(exp_fwd.pop_front());
            end
            if (d2p_cmd_wr_en) take_status(d2p_cmd_din);
        end
        pend = exp_status.size() + exp_fwd.size() + exp_addr.size();
    end

endmodule

// ==== dv/dram_domain_tb.sv ====
`timescale 1ns/1ns

module dram_domain_tb;
    import dram_domain_pkg::*;

    // 90 host words and 17 beats under random stalls fit many times over
    localparam int TIMEOUT_CYCLES = 20000;

    logic ui_clk, rst, init_calib_complete;
    cmd_word_t p2d_cmd_dout, d2p_cmd_din, d2a_cmd_din, a2d_cmd_dout;
    logic p2d_cmd_empty, p2d_cmd_rd_en, p2d_data_empty, p2d_data_rd_en;
    logic d2p_cmd_wr_en, d2p_cmd_full, d2a_cmd_wr_en, d2a_cmd_full;
    logic a2d_cmd_empty, a2d_cmd_rd_en;
    logic [DATA_W-1:0] p2d_data_dout, app_wdf_data, app_rd_data;
    logic app_en, app_wdf_wren, app_rdy, app_wdf_rdy, app_rd_data_valid;
    app_cmd_e app_cmd;
    logic [APP_ADDR_W-1:0] app_addr, rd_addr;
    int error_count, pending;

    cmd_word_t cmd_q[$];
    cmd_word_t a2d_q[$];
    logic [DATA_W-1:0] data_q[$];
    logic [DATA_W-1:0] mem [logic [APP_ADDR_W-1:0]];
    logic [31:0] lfsr;
    bit pop_cmd, pop_data, pop_a2d;
    int rd_delay = 0;
    int cycles = 0;

    tb_clock tb_clock_i (.ui_clk(ui_clk));
    dram_domain dram_domain_i (.*);
    dram_domain_checker dram_domain_checker_i (.*);

    function automatic logic [31:0] lfsr_next(logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic rand_bits(input int n, output logic [DATA_W-1:0] v);
        v = '0;
        repeat (n) begin
            lfsr = lfsr_next(lfsr);
            v = {v[DATA_W-2:0], lfsr[0]};
        end
    endtask

    // fifo pops and memory traffic sampled mid-cycle
    always @(negedge ui_clk) begin
        pop_cmd  = p2d_cmd_rd_en;
        pop_data = p2d_data_rd_en;
        pop_a2d  = a2d_cmd_rd_en;
        if (app_en && app_wdf_wren && app_cmd == app_write) mem[app_addr] = app_wdf_data;
        if (app_en && app_cmd == app_read) begin
            rd_delay = 3;
            rd_addr = app_addr;
        end
    end

    always @(posedge ui_clk) begin
        logic [DATA_W-1:0] r;
        #1;
        if (pop_cmd) void'(cmd_q.pop_front());
        if (pop_data) void'(data_q.pop_front());
        if (pop_a2d) void'(a2d_q.pop_front());
        pop_cmd = 0;
        pop_data = 0;
        pop_a2d = 0;
        p2d_cmd_empty  = cmd_q.size() == 0;
        p2d_cmd_dout   = p2d_cmd_empty ? '0 : cmd_q[0];
        p2d_data_empty = data_q.size() == 0;
        p2d_data_dout  = p2d_data_empty ? '0 : data_q[0];
        a2d_cmd_empty  = a2d_q.size() == 0;
        a2d_cmd_dout   = a2d_cmd_empty ? '0 : a2d_q[0];
        rand_bits(8, r);
        d2p_cmd_full = &r[1:0];
        d2a_cmd_full = &r[3:2];
        app_rdy      = |r[5:4];
        app_wdf_rdy  = |r[7:6];
        app_rd_data_valid = 1'b0;
        if (rd_delay > 0) begin
            rd_delay--;
            if (rd_delay == 0) begin
                app_rd_data_valid = 1'b1;
                app_rd_data = mem.exists(rd_addr) ? mem[rd_addr] : '0;
            end
        end
    end

    always @(posedge ui_clk) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout after %0d cycles, %0d checks still open", cycles, pending);
            $display("Testbench failed");
            $finish;
        end
    end

    // the asic done word counts as open until the design releases it
    task automatic wait_drained();
        while (cmd_q.size() != 0 || data_q.size() != 0 || a2d_q.size() != 0 ||
               pending != 0) begin
            @(posedge ui_clk);
        end
        repeat (2) @(posedge ui_clk);
    endtask

    // done word goes in first and must wait for the fortieth config word
    task automatic config_round(input logic [PAYLOAD_W-1:0] done_payload);
        logic [DATA_W-1:0] r;
        a2d_q.push_back({done_payload, op_asic_done});
        for (int i = 0; i < CONFIG_WORDS; i++) begin
            rand_bits(PAYLOAD_W, r);
            cmd_q.push_back({r[PAYLOAD_W-1:0], op_config});
        end
    endtask

    task automatic window_run(input logic [ADDR_W-1:0] base, input int n);
        logic [ADDR_W-1:0] last;
        logic [DATA_W-1:0] r;
        last = base + ADDR_W'(8 * (n - 1));
        cmd_q.push_back({1'b0, base[15:0], op_window});
        cmd_q.push_back({1'b0, base[31:16], op_window});
        cmd_q.push_back({1'b0, last[15:0], op_window});
        cmd_q.push_back({1'b0, last[31:16], op_window});
        wait_drained();
        for (int i = 0; i < n; i++) begin
            rand_bits(DATA_W, r);
            data_q.push_back(r);
        end
        wait_drained();
        cmd_q.push_back({17'd0, op_count});
        wait_drained();
    endtask

    initial begin
        rst = 1'b1;
        init_calib_complete = 1'b0;
        lfsr = 32'h042660a1;
        p2d_cmd_dout = '0;
        p2d_cmd_empty = 1'b1;
        p2d_data_dout = '0;
        p2d_data_empty = 1'b1;
        a2d_cmd_dout = '0;
        a2d_cmd_empty = 1'b1;
        d2p_cmd_full = 1'b0;
        d2a_cmd_full = 1'b0;
        app_rdy = 1'b0;
        app_wdf_rdy = 1'b0;
        app_rd_data = '0;
        app_rd_data_valid = 1'b0;
        repeat (16) @(posedge ui_clk);
        #1 rst = 1'b0;
        repeat (4) @(posedge ui_clk);
        #1 init_calib_complete = 1'b1;
        @(posedge ui_clk);
        config_round(17'h1d2c1);
        window_run(32'h0000_4000, 12);
        config_round(17'h00a5f);
        window_run(32'h0ffe_0000, 5);
        wait_drained();
        $display("checks done: %0d errors, %0d expectations open", error_count, pending);
        if (error_count == 0 && pending == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// ==== filelist.f ====
rtl/dram_domain_pkg.sv
rtl/host_cmd_engine.sv
rtl/app_port_ctrl.sv
rtl/status_mux.sv
rtl/dram_domain.sv
dv/tb_clock.sv
dv/dram_domain_asserts.sv
dv/dram_domain_checker.sv
dv/dram_domain_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module dram_domain_tb -f filelist.f -o dram_domain_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/dram_domain_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^Testbench passed$" sim.log; then
    exit 0
fi
exit 1
